// ==== build.f ====
+incdir+source
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/micro_sequencer.sv
source/control_unit.sv
source/datapath.sv
source/unified_memory.sv
source/multicycle_cpu.sv
tb/multicycle_cpu_properties.sv
tb/multicycle_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: multicycle_cpu

sources:
  - target: rtl
    include_dirs:
      - source
    files:
      - source/cpu_pkg.sv
      - source/alu.sv
      - source/register_file.sv
      - source/micro_sequencer.sv
      - source/control_unit.sv
      - source/datapath.sv
      - source/unified_memory.sv
      - source/multicycle_cpu.sv
  - target: test
    files:
      - tb/multicycle_cpu_properties.sv
      - tb/multicycle_cpu_tb.sv

// ==== tb/program.hex ====
// One 32-bit instruction word per line, loaded from byte address 0 upward.
// The text after each word is its byte address and assembly.
00500093  // 00 addi x1, x0, 5
ffd00113  // 04 addi x2, x0, -3
002081b3  // 08 add  x3, x1, x2
40208233  // 0c sub  x4, x1, x2
001122b3  // 10 slt  x5, x2, x1
0020f333  // 14 and  x6, x1, x2
0020e3b3  // 18 or   x7, x1, x2
0020c433  // 1c xor  x8, x1, x2
003094b3  // 20 sll  x9, x1, x3
00315533  // 24 srl  x10, x2, x3
00409593  // 28 slli x11, x1, 4
01c15613  // 2c srli x12, x2, 28
00012693  // 30 slti x13, x2, 0
10006713  // 34 ori  x14, x0, 0x100
00472423  // 38 sw   x4, 8(x14)
00872783  // 3c lw   x15, 8(x14)
00708013  // 40 addi x0, x1, 7
00318463  // 44 beq  x3, x3, +8
06300993  // 48 addi x19, x0, 99 (skipped)
00114463  // 4c blt  x2, x1, +8
06200993  // 50 addi x19, x0, 98 (skipped)
00109463  // 54 bne  x1, x1, +8
00115463  // 58 bge  x2, x1, +8
00100a13  // 5c addi x20, x0, 1
00800aef  // 60 jal  x21, +8
06100993  // 64 addi x19, x0, 97 (skipped)
07000b13  // 68 addi x22, x0, 0x70
004b0be7  // 6c jalr x23, 4(x22)
06000993  // 70 addi x19, x0, 96 (skipped)
00300893  // 74 addi x17, x0, 3
00000073  // 78 ecall
05500c13  // 7c addi x24, x0, 0x55
00a00893  // 80 addi x17, x0, 10
00000073  // 84 ecall
00100c93  // 88 addi x25, x0, 1 (after halt)
00172023  // 8c sw   x1, 0(x14) (after halt)

// ==== tb/multicycle_cpu_tb.sv ====
`default_nettype none

module multicycle_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROGRAM_WORDS    = 36;
    localparam int MAX_INSTR_CYCLES = 5;
    // Twice the worst case over all words, with slack for reset and the tail.
    localparam int TIMEOUT_CYCLES   = 2 * (PROGRAM_WORDS + 4) * MAX_INSTR_CYCLES;
    localparam int HALT_TAIL_CYCLES = 10;

    logic        clk;
    logic        reset;
    logic        halted;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    logic [4:0]  exp_rd_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_wdata_q[$];
    logic        halt_seen = 1'b0;
    int          cycle_count = 0;

    multicycle_cpu u_multicycle_cpu (
        .clk          (clk),
        .reset        (reset),
        .halted       (halted),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic expect_commit(input logic [4:0] rd, input logic [31:0] data);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(data);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr_q.push_back(addr);
        exp_wdata_q.push_back(data);
    endtask

    // Hand-worked results of tb/program.hex, in program order.
    task automatic load_expected();
        expect_commit(5'd1,  32'h0000_0005);
        expect_commit(5'd2,  32'hffff_fffd);  // -3.
        expect_commit(5'd3,  32'h0000_0002);
        expect_commit(5'd4,  32'h0000_0008);
        expect_commit(5'd5,  32'h0000_0001);  // slt -3 < 5.
        expect_commit(5'd6,  32'h0000_0005);
        expect_commit(5'd7,  32'hffff_fffd);
        expect_commit(5'd8,  32'hffff_fff8);
        expect_commit(5'd9,  32'h0000_0014);
        expect_commit(5'd10, 32'h3fff_ffff);  // Logical shift without sign fill.
        expect_commit(5'd11, 32'h0000_0050);
        expect_commit(5'd12, 32'h0000_000f);
        expect_commit(5'd13, 32'h0000_0001);
        expect_commit(5'd14, 32'h0000_0100);
        expect_store(32'h0000_0108, 32'h0000_0008);
        expect_commit(5'd15, 32'h0000_0008);  // Load of the stored word.
        // Write to x0 and two taken branches leave no trace here.
        expect_commit(5'd20, 32'h0000_0001);
        expect_commit(5'd21, 32'h0000_0064);  // jal link.
        expect_commit(5'd22, 32'h0000_0070);
        expect_commit(5'd23, 32'h0000_0070);  // jalr link.
        expect_commit(5'd17, 32'h0000_0003);
        expect_commit(5'd24, 32'h0000_0055);  // Runs after the non-halting ecall.
        expect_commit(5'd17, 32'h0000_000a);
    endtask

    task automatic check_commit();
        logic [4:0]  rd;
        logic [31:0] data;
        if (halt_seen || exp_rd_q.size() == 0) begin
            $display("Unexpected register write to x%0d", commit_rd);
            stop_on_error();
        end else begin
            rd   = exp_rd_q.pop_front();
            data = exp_data_q.pop_front();
            assert (commit_rd === rd) else begin
                $display("ERROR commit_rd expected 0x%h actual 0x%h", rd, commit_rd);
                stop_on_error();
            end
            assert (commit_data === data) else begin
                $display("ERROR commit_data x%0d expected 0x%h actual 0x%h",
                         rd, data, commit_data);
                stop_on_error();
            end
        end
    endtask

    task automatic check_store();
        logic [31:0] addr;
        logic [31:0] data;
        if (halt_seen || exp_addr_q.size() == 0) begin
            $display("Unexpected memory write to address 0x%h", store_addr);
            stop_on_error();
        end else begin
            addr = exp_addr_q.pop_front();
            data = exp_wdata_q.pop_front();
            assert (store_addr === addr) else begin
                $display("ERROR store_addr expected 0x%h actual 0x%h", addr, store_addr);
                stop_on_error();
            end
            assert (store_data === data) else begin
                $display("ERROR store_data expected 0x%h actual 0x%h", data, store_data);
                stop_on_error();
            end
        end
    endtask

    // Outputs have settled by the falling edge.
    always @(negedge clk) begin
        if (!reset) begin
            if (commit_valid) check_commit();
            if (store_valid) check_store();
            if (halt_seen) begin
                assert (halted === 1'b1) else begin
                    $display("halted dropped after the processor stopped");
                    stop_on_error();
                end
            end
            if (halted === 1'b1) halt_seen = 1'b1;
            if (u_multicycle_cpu.u_control_unit.u_properties.property_failed) begin
                $display("A control unit property failed");
                stop_on_error();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: processor never halted");
            stop_on_error();
        end
    end

    initial begin
        reset = 1'b1;
        load_expected();
        $readmemh("tb/program.hex", u_multicycle_cpu.u_memory.mem);
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        wait (halted === 1'b1);
        repeat (HALT_TAIL_CYCLES) @(posedge clk);  // Stray writes would show here.
        if (exp_rd_q.size() == 0 && exp_addr_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Processor halted with %0d commits and %0d stores still expected",
                     exp_rd_q.size(), exp_addr_q.size());
            stop_on_error();
        end
    end

endmodule

`default_nettype wire

// ==== tb/multicycle_cpu_properties.sv ====
`default_nettype none

module multicycle_cpu_properties import cpu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  micro_state_t state,
    input  wire logic   bcond,
    input  wire logic   halted,
    input  wire logic   mem_write,
    input  wire logic   reg_write
);
    timeunit 1ns;
    timeprecision 1ps;

    logic property_failed = 1'b0;  // Read by the testbench monitor.

    reset_to_fetch: assert property (@(posedge clk) reset |=> state == IF1)
        else begin
            $error("State is not IF1 one cycle after reset.");
            property_failed = 1'b1;
        end

    fetch_to_decode: assert property (@(posedge clk) disable iff (reset)
        (state == IF1 && !halted) |=> state == IF2)
        else begin
            $error("IF1 did not step to IF2 on a running machine.");
            property_failed = 1'b1;
        end

    // A taken branch is the only way into MEM3.
    branch_follows_bcond: assert property (@(posedge clk) disable iff (reset)
        state == MEM2 |=> (state == MEM3) == $past(bcond))
        else begin
            $error("MEM2 exit disagrees with bcond.");
            property_failed = 1'b1;
        end

    single_write: assert property (@(posedge clk) !(mem_write && reg_write))
        else begin
            $error("Memory write and register write in the same cycle.");
            property_failed = 1'b1;
        end

endmodule

bind control_unit multicycle_cpu_properties u_properties (
    .clk       (clk),
    .reset     (reset),
    .state     (state),
    .bcond     (bcond),
    .halted    (halted),
    .mem_write (mem_write),
    .reg_write (reg_write)
);

`default_nettype wire

// ==== source/multicycle_cpu.sv ====
`default_nettype none

module multicycle_cpu import cpu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    output logic        halted,
    output logic        commit_valid,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_data,
    output logic        store_valid,
    output logic [31:0] store_addr,
    output logic [31:0] store_data
);

    logic        pc_write_cond, pc_write, pc_source, i_or_d, ir_write;
    logic        mem_read, mem_write, mem_to_reg, reg_write;
    logic        alu_src_a, bcond;
    logic [1:0]  alu_src_b;
    logic [6:0]  opcode;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;
    alu_op_t     alu_op;

    control_unit u_control_unit (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .bcond         (bcond),
        .halted        (halted),
        .pc_write_cond (pc_write_cond),
        .pc_write      (pc_write),
        .pc_source     (pc_source),
        .i_or_d        (i_or_d),
        .ir_write      (ir_write),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_to_reg    (mem_to_reg),
        .reg_write     (reg_write),
        .alu_op        (alu_op),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b)
    );

    datapath u_datapath (
        .clk           (clk),
        .reset         (reset),
        .pc_write_cond (pc_write_cond),
        .pc_write      (pc_write),
        .pc_source     (pc_source),
        .i_or_d        (i_or_d),
        .ir_write      (ir_write),
        .mem_read      (mem_read),
        .mem_to_reg    (mem_to_reg),
        .reg_write     (reg_write),
        .alu_op        (alu_op),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .mem_rdata     (mem_rdata),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .opcode        (opcode),
        .bcond         (bcond),
        .halted        (halted),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_data   (commit_data)
    );

    unified_memory u_memory (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .write (mem_write),
        .rdata (mem_rdata)
    );

    assign store_valid = mem_write;
    assign store_addr  = mem_addr;
    assign store_data  = mem_wdata;

endmodule

`default_nettype wire

// ==== source/unified_memory.sv ====
`default_nettype none

`include "cpu_defines.svh"

module unified_memory (
    input  wire logic        clk,
    input  wire logic [31:0] addr,
    input  wire logic [31:0] wdata,
    input  wire logic        write,
    output logic [31:0]      rdata
);

    logic [31:0] mem [`MEM_WORDS];  // Filled by the testbench.
    logic [$clog2(`MEM_WORDS)-1:0] word_idx;

    // Byte address to word index.
    assign word_idx = addr[$clog2(`MEM_WORDS)+1:2];
    assign rdata    = mem[word_idx];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[word_idx] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== source/datapath.sv ====
`default_nettype none

`include "cpu_defines.svh"

module datapath import cpu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        pc_write_cond,
    input  wire logic        pc_write,
    input  wire logic        pc_source,
    input  wire logic        i_or_d,
    input  wire logic        ir_write,
    input  wire logic        mem_read,
    input  wire logic        mem_to_reg,
    input  wire logic        reg_write,
    input  alu_op_t          alu_op,
    input  wire logic        alu_src_a,
    input  wire logic [1:0]  alu_src_b,
    input  wire logic [31:0] mem_rdata,
    output logic [31:0]      mem_addr,
    output logic [31:0]      mem_wdata,
    output logic [6:0]       opcode,
    output logic             bcond,
    output logic             halted,
    output logic             commit_valid,
    output logic [4:0]       commit_rd,
    output logic [31:0]      commit_data
);

    instr_u      ir;
    instr_u      fetch_word;
    logic [31:0] pc, mdr, a_reg, b_reg, alu_out;
    logic [31:0] rdata1, rdata2, imm, src_a, src_b, alu_result, pc_next, wdata;
    logic [4:0]  rs1_sel;

    // Operand reads follow the word being fetched, so A and B are valid from IF2.
    assign fetch_word = ir_write ? mem_rdata : ir;
    assign rs1_sel    = (fetch_word.r.opcode == `OP_ECALL) ? 5'd17 : fetch_word.r.rs1;

    always_comb begin
        case (ir.r.opcode)
            `OP_STORE:  imm = {{20{ir.r.funct7[6]}}, ir.r.funct7, ir.r.rd};
            `OP_BRANCH: imm = {{20{ir.r.funct7[6]}}, ir.r.rd[0], ir.r.funct7[5:0],
                               ir.r.rd[4:1], 1'b0};
            `OP_JAL:    imm = {{12{ir.r.funct7[6]}}, ir.r.rs1, ir.r.funct3, ir.r.rs2[0],
                               ir.r.funct7[5:0], ir.r.rs2[4:1], 1'b0};
            default:    imm = {{20{ir.i.imm12[11]}}, ir.i.imm12};
        endcase
        case (alu_src_b)
            2'b00:   src_b = b_reg;
            2'b01:   src_b = 32'd4;
            default: src_b = imm;
        endcase
    end

    assign src_a   = alu_src_a ? a_reg : pc;
    assign pc_next = (pc_source ? alu_out : alu_result) & 32'hffff_fffe;  // jalr drops bit 0.
    assign wdata   = mem_to_reg ? mdr : alu_out;

    register_file u_register_file (
        .clk    (clk),
        .reset  (reset),
        .rs1    (rs1_sel),
        .rs2    (fetch_word.r.rs2),
        .rd     (ir.r.rd),
        .write  (reg_write),
        .wdata  (wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu u_alu (
        .alu_op (alu_op),
        .instr  (ir),
        .a      (src_a),
        .b      (src_b),
        .result (alu_result),
        .bcond  (bcond)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end else begin
            if (pc_write || (pc_write_cond && !bcond)) pc <= pc_next;
            if (pc_write && ir.r.opcode == `OP_ECALL && a_reg == `HALT_CODE) halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_write) ir <= mem_rdata;
        if (mem_read) mdr <= mem_rdata;
        a_reg   <= rdata1;
        b_reg   <= rdata2;
        alu_out <= alu_result;
    end

    assign mem_addr     = i_or_d ? alu_out : pc;
    assign mem_wdata    = b_reg;
    assign opcode       = ir.r.opcode;
    assign commit_valid = reg_write && (ir.r.rd != 5'd0);
    assign commit_rd    = ir.r.rd;
    assign commit_data  = wdata;

endmodule

`default_nettype wire

// ==== source/control_unit.sv ====
`default_nettype none

`include "cpu_defines.svh"

module control_unit import cpu_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [6:0] opcode,
    input  wire logic       bcond,
    input  wire logic       halted,
    output logic            pc_write_cond,
    output logic            pc_write,
    output logic            pc_source,
    output logic            i_or_d,
    output logic            ir_write,
    output logic            mem_read,
    output logic            mem_write,
    output logic            mem_to_reg,
    output logic            reg_write,
    output alu_op_t         alu_op,
    output logic            alu_src_a,
    output logic [1:0]      alu_src_b
);

    micro_state_t state;
    micro_state_t next_state;

    micro_sequencer u_micro_sequencer (
        .state      (state),
        .opcode     (opcode),
        .bcond      (bcond),
        .next_state (next_state)
    );

    always_ff @(posedge clk) begin
        if (reset || halted) begin
            state <= IF1;  // A halted machine parks in fetch.
        end else begin
            state <= next_state;
        end
    end

    // alu_src_a picks PC or A. alu_src_b picks B, four or the immediate.
    always_comb begin
        pc_write_cond = 1'b0;
        pc_write      = 1'b0;
        pc_source     = 1'b0;
        i_or_d        = 1'b0;
        ir_write      = 1'b0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        mem_to_reg    = 1'b0;
        reg_write     = 1'b0;
        alu_op        = ADD_OP;
        alu_src_a     = 1'b0;
        alu_src_b     = 2'b01;
        case (state)
            IF1: begin
                mem_read = 1'b1;
                ir_write = 1'b1;
            end
            IF2: begin
                if (opcode == `OP_ECALL) begin
                    pc_write = 1'b1;
                end else if (opcode == `OP_ARITH_IMM) begin
                    alu_src_a = 1'b1;
                    alu_src_b = 2'b10;
                    alu_op    = FUNCT_OP;
                end
            end
            IF3: begin
                alu_src_a = 1'b1;  // Effective address.
                alu_src_b = 2'b10;
            end
            IF4: begin
                mem_read = 1'b1;
                i_or_d   = 1'b1;
            end
            ID: begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                pc_write   = 1'b1;
            end
            EX1: begin
                mem_write = 1'b1;
                i_or_d    = 1'b1;
                pc_write  = 1'b1;
            end
            EX2: begin
                alu_src_a = 1'b1;
                alu_src_b = 2'b00;
                alu_op    = FUNCT_OP;
            end
            MEM1: begin
                reg_write = 1'b1;
                pc_write  = 1'b1;
            end
            MEM2: begin
                alu_src_a     = 1'b1;
                alu_src_b     = 2'b00;
                alu_op        = BRANCH_OP;
                pc_write_cond = 1'b1;  // A branch not taken loads PC+4 from ALUOut.
                pc_source     = 1'b1;
            end
            MEM3: begin
                alu_src_b = 2'b10;
                pc_write  = 1'b1;
            end
            MEM4: begin
                reg_write = 1'b1;
                alu_src_b = 2'b10;
                pc_write  = 1'b1;
            end
            WB: begin
                reg_write = 1'b1;
                alu_src_a = 1'b1;
                alu_src_b = 2'b10;
                pc_write  = 1'b1;
            end
            default: ;
        endcase
        if (halted) begin
            pc_write_cond = 1'b0;
            pc_write      = 1'b0;
            ir_write      = 1'b0;
            mem_write     = 1'b0;
            reg_write     = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/micro_sequencer.sv ====
`default_nettype none

`include "cpu_defines.svh"

module micro_sequencer import cpu_pkg::*; (
    input  micro_state_t     state,
    input  wire logic [6:0]  opcode,
    input  wire logic        bcond,
    output micro_state_t     next_state
);

    always_comb begin
        next_state = IF1;
        case (state)
            IF1: next_state = IF2;
            IF2: begin
                case (opcode)
                    `OP_ARITH:     next_state = EX2;
                    `OP_ARITH_IMM: next_state = MEM1;
                    `OP_LOAD:      next_state = IF3;
                    `OP_STORE:     next_state = IF3;
                    `OP_BRANCH:    next_state = MEM2;
                    `OP_JAL:       next_state = MEM4;
                    `OP_JALR:      next_state = WB;
                    default:       next_state = IF1;  // ecall and unknown words.
                endcase
            end
            IF3:  next_state = (opcode == `OP_STORE) ? EX1 : IF4;
            IF4:  next_state = ID;
            EX2:  next_state = MEM1;
            MEM2: next_state = bcond ? MEM3 : IF1;
            default: next_state = IF1;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`default_nettype none

module register_file (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [4:0]  rs1,
    input  wire logic [4:0]  rs2,
    input  wire logic [4:0]  rd,
    input  wire logic        write,
    input  wire logic [31:0] wdata,
    output logic [31:0]      rdata1,
    output logic [31:0]      rdata2
);

    logic [31:0] regs [32];

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (write && rd != 5'd0) begin
            regs[rd] <= wdata;  // x0 stays zero.
        end
    end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`default_nettype none

`include "cpu_defines.svh"

module alu import cpu_pkg::*; (
    input  alu_op_t           alu_op,
    input  instr_u            instr,
    input  wire logic [31:0]  a,
    input  wire logic [31:0]  b,
    output logic [31:0]       result,
    output logic              bcond
);

    logic       less;
    logic       is_sub;
    logic [4:0] shamt;

    assign less   = $signed(a) < $signed(b);
    assign is_sub = (instr.r.opcode == `OP_ARITH) && instr.r.funct7[5];  // Only R-type subtracts.
    assign shamt  = b[4:0];

    always_comb begin
        case (alu_op)
            ADD_OP:    result = a + b;
            BRANCH_OP: result = a - b;
            default: begin
                case (instr.r.funct3)
                    3'b000:  result = is_sub ? a - b : a + b;
                    3'b001:  result = a << shamt;
                    3'b010:  result = {31'd0, less};
                    3'b100:  result = a ^ b;
                    3'b101:  result = instr.r.funct7[5] ? 32'($signed(a) >>> shamt) : a >> shamt;
                    3'b110:  result = a | b;
                    3'b111:  result = a & b;
                    default: result = a + b;
                endcase
            end
        endcase
    end

    always_comb begin
        case (instr.r.funct3)
            3'b000:  bcond = (result == 32'd0);
            3'b001:  bcond = (result != 32'd0);
            3'b100:  bcond = less;
            3'b101:  bcond = !less;
            default: bcond = 1'b0;
        endcase
        if (alu_op != BRANCH_OP) bcond = 1'b0;
    end

endmodule

`default_nettype wire

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // Micro-states of the multicycle controller.
    typedef enum logic [3:0] {
        IF1, IF2, IF3, IF4,
        ID,
        EX1, EX2,
        MEM1, MEM2, MEM3, MEM4,
        WB
    } micro_state_t;

    typedef enum logic [1:0] {
        ADD_OP    = 2'b00,
        BRANCH_OP = 2'b01,
        FUNCT_OP  = 2'b10
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // One instruction word, seen as register form or immediate form.
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_u;

endpackage

`default_nettype wire

// ==== source/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Major opcodes of the supported RV32I subset.
`define OP_ARITH     7'b0110011
`define OP_ARITH_IMM 7'b0010011
`define OP_LOAD      7'b0000011
`define OP_STORE     7'b0100011
`define OP_BRANCH    7'b1100011
`define OP_JAL       7'b1101111
`define OP_JALR      7'b1100111
`define OP_ECALL     7'b1110011

`define HALT_CODE    32'd10  // Value in x17 that requests a halt.
`define MEM_WORDS    256
`define RESET_PC     32'h0000_0000

`endif
